/* dv/hwpe_ctrl_checker.sv */
// Protocol assertions on the engine start pulse, bound into hwpe_ctrl_top
// Assumes start_o and status_o as produced by the scheduler
module hwpe_ctrl_checker
  import hwpe_ctrl_pkg::*;
(
  input logic  clk_i,
  input logic  rst_ni,
  input logic  start_i,
  input data_t status_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // START lasts exactly one cycle
  single_cycle_start: assert property (@(posedge clk_i) disable iff (!rst_ni)
    start_i |=> !start_i)
    else $error("start_o was high for two cycles in a row");

  start_has_context: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(start_i) |-> (status_i != '0))  // The started context is still occupied
    else $error("start_o rose with no status byte set");

  quiet_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !start_i)
    else $error("start_o was high during reset");

endmodule

bind hwpe_ctrl_top hwpe_ctrl_checker i_hwpe_ctrl_checker (
  .clk_i    ( clk_i    ),
  .rst_ni   ( rst_ni   ),
  .start_i  ( start_o  ),
  .status_i ( status_o )
);

/* dv/hwpe_ctrl_input.txt */
# op addr wdata expected, all hex; W write, R read and compare rdata_o
# D done pulse, S wait for start_o and compare params_o[0], C clear pulse
R 01 00000000 00000000
R 01 00000000 fffffffe
W 08 000000a0 00000000
R 08 00000000 000000a0
W 00 00000001 00000000
S 00 00000000 000000a0
R 01 00000000 00000001
W 08 000000b0 00000000
R 08 00000000 000000b0
W 00 00000001 00000000
R 01 00000000 ffffffff
R 03 00000000 00000101
D 00 00000000 00000000
S 00 00000000 000000b0
R 03 00000000 00000100
R 04 00000000 00000001
D 00 00000000 00000000
R 03 00000000 00000000
R 04 00000000 00000002
R 01 00000000 00000002
W 08 000000c0 00000000
R 08 00000000 000000c0
W 00 00000001 00000000
S 00 00000000 000000c0
D 00 00000000 00000000
R 03 00000000 00000000
R 04 00000000 00000003
R 02 00000000 00000002
R 02 00000000 00000000
R 06 00000000 deadbeef
R 01 00000000 00000003
C 00 00000000 00000000
R 01 00000000 00000000
R 03 00000000 00000000

/* dv/hwpe_ctrl_tb.sv */
// Testbench for hwpe_ctrl_top with 2 contexts and 4 parameter registers
// Operations and expected values come from dv/hwpe_ctrl_input.txt, run from the project root
// Inputs change on the falling edge and outputs are sampled there too
module hwpe_ctrl_tb
  import hwpe_ctrl_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_CONTEXT     = 2;
  localparam int unsigned N_IO_REGS     = 4;
  localparam int unsigned START_TIMEOUT = 50;  // Cycles

  logic                  clk_i;
  logic                  rst_ni;
  logic                  clear_i;
  logic                  done_i;
  bus_req_t              bus_req_i;
  data_t                 rdata_o;
  logic                  start_o;
  data_t                 status_o;
  data_t [N_IO_REGS-1:0] params_o;

  int err_cnt;
  int timeout_cnt;
  int file_err_cnt;  // Missing file, bad lines
  int check_cnt;
  int line_no;

  hwpe_ctrl_top #(
    .N_CONTEXT ( N_CONTEXT ),
    .N_IO_REGS ( N_IO_REGS )
  ) hwpe_ctrl_top_i (
    .clk_i     ( clk_i     ),
    .rst_ni    ( rst_ni    ),
    .clear_i   ( clear_i   ),
    .bus_req_i ( bus_req_i ),
    .done_i    ( done_i    ),
    .rdata_o   ( rdata_o   ),
    .start_o   ( start_o   ),
    .status_o  ( status_o  ),
    .params_o  ( params_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic check_data(input string name, input data_t got, input data_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %s at input line %0d: got %h, expected %h", name, line_no, got, exp);
    end
  endtask

  task automatic check_status(input data_t got, input data_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR status_o at input line %0d: got %h, expected %h", line_no, got, exp);
    end
  endtask

  // One-cycle strobe, sampled by the next rising edge
  task automatic bus_access(input logic wren, input reg_addr_t addr, input data_t wdata);
    bus_req_i.req   = 1'b1;
    bus_req_i.wren  = wren;
    bus_req_i.addr  = addr;
    bus_req_i.wdata = wdata;
    @(negedge clk_i);
    bus_req_i = '0;
  endtask

  task automatic read_and_check(input reg_addr_t addr, input data_t exp);
    bus_access(1'b0, addr, '0);
    check_data("rdata_o", rdata_o, exp);  // Registered one cycle after the strobe
    if (addr == REG_STATUS) check_status(status_o, exp);
  endtask

  task automatic pulse_done();
    done_i = 1'b1;
    @(negedge clk_i);
    done_i = 1'b0;
  endtask

  task automatic pulse_clear();
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
  endtask

  // start_o may already be high when a done pulse started the next context
  task automatic wait_for_start(input data_t exp);
    int n;
    n = 0;
    while (!start_o && n < START_TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!start_o) begin
      timeout_cnt++;
      $display("Input line %0d: start_o never came within %0d cycles", line_no, START_TIMEOUT);
    end else begin
      check_data("params_o[0]", params_o[0], exp);
      @(negedge clk_i);  // Engine takes start_o here, done_i may follow
    end
  endtask

  task automatic run_stimulus_file();
    int    fd;
    int    n;
    string line;
    byte   op;
    data_t addr_w;
    data_t wdata;
    data_t exp;
    fd = $fopen("dv/hwpe_ctrl_input.txt", "r");
    if (fd == 0) begin
      file_err_cnt++;
      $display("Could not open the stimulus file dv/hwpe_ctrl_input.txt");
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      line_no++;
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;  // Blank or comment
      n = $sscanf(line, "%c %h %h %h", op, addr_w, wdata, exp);
      if (n != 4) begin
        file_err_cnt++;
        $display("Input line %0d does not hold four fields", line_no);
        continue;
      end
      case (op)
        "W": bus_access(1'b1, reg_addr_t'(addr_w), wdata);
        "R": read_and_check(reg_addr_t'(addr_w), exp);
        "D": pulse_done();
        "S": wait_for_start(exp);
        "C": pulse_clear();
        default: begin
          file_err_cnt++;
          $display("Input line %0d has an unknown operation letter", line_no);
        end
      endcase
    end
    $fclose(fd);
  endtask

  initial begin
    bus_req_i    = '0;
    done_i       = 1'b0;
    clear_i      = 1'b0;
    rst_ni       = 1'b0;
    err_cnt      = 0;
    timeout_cnt  = 0;
    file_err_cnt = 0;
    check_cnt    = 0;
    line_no      = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    run_stimulus_file();
    $display("checks %0d, errors %0d, timeouts %0d, file errors %0d",
             check_cnt, err_cnt, timeout_cnt, file_err_cnt);
    if (err_cnt == 0 && timeout_cnt == 0 && file_err_cnt == 0 && check_cnt > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* hwpe_ctrl.f */
logic/hwpe_ctrl_pkg.sv
logic/job_sched_fsm.sv
logic/job_counters.sv
logic/param_store.sv
logic/reg_readback.sv
logic/hwpe_ctrl_top.sv
dv/hwpe_ctrl_checker.sv
dv/hwpe_ctrl_tb.sv

/* logic/hwpe_ctrl_pkg.sv */
// Shared types and register map of the HWPE control register file
// Register indices are word indices on the 5-bit processor address
// Up to 4 contexts and 8 parameter registers per context
package hwpe_ctrl_pkg;

  typedef logic [31:0] data_t;      // Register word
  typedef logic [4:0]  reg_addr_t;  // Word index
  typedef logic [7:0]  job_id_t;
  typedef logic [1:0]  ctx_id_t;    // Context index

  // Processor access, one-cycle strobe when req is high
  typedef struct packed {
    logic      req;
    logic      wren;
    reg_addr_t addr;
    data_t     wdata;
  } bus_req_t;

  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_START,
    SCHED_RUN
  } sched_state_e;

  // Mandatory registers
  localparam reg_addr_t REG_TRIGGER    = 5'd0;  // Write only
  localparam reg_addr_t REG_ACQUIRE    = 5'd1;  // Read only, claims a context
  localparam reg_addr_t REG_FINISHED   = 5'd2;  // Cleared by a read
  localparam reg_addr_t REG_STATUS     = 5'd3;
  localparam reg_addr_t REG_RUNNING_ID = 5'd4;

  // Parameter register k sits at REG_PARAM_BASE + k
  localparam reg_addr_t REG_PARAM_BASE = 5'd8;

  // ACQUIRE answers when no job id is handed out
  localparam data_t RESP_OFFLOAD_BUSY = 32'hffff_fffe;
  localparam data_t RESP_ALL_CTX_BUSY = 32'hffff_ffff;

  localparam data_t RESP_UNMAPPED = 32'hdead_beef;

  // Defaults, normally overridden from the top level
  localparam int unsigned DEF_N_CONTEXT = 2;
  localparam int unsigned DEF_N_IO_REGS = 4;

endpackage

/* logic/hwpe_ctrl_top.sv */
// HWPE control register file top level
// N_CONTEXT 1 to 4, N_IO_REGS 1 to 8
// The engine must take start_o when it comes; params_o is valid until done_i
module hwpe_ctrl_top
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT = DEF_N_CONTEXT,
  parameter int unsigned N_IO_REGS = DEF_N_IO_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  bus_req_t              bus_req_i,
  input  logic                  done_i,
  output data_t                 rdata_o,
  output logic                  start_o,
  output data_t                 status_o,
  output data_t [N_IO_REGS-1:0] params_o
);

  logic    acq_grant;
  logic    acq_busy;
  logic    acq_full;
  logic    done_pulse;
  ctx_id_t fill_ctx;
  ctx_id_t run_ctx;
  job_id_t offload_id;
  job_id_t running_id;
  data_t   finished_cnt;
  data_t   rd_param;

  job_sched_fsm #(
    .N_CONTEXT ( N_CONTEXT )
  ) i_job_sched_fsm (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .bus_req_i    ( bus_req_i  ),
    .done_i       ( done_i     ),
    .acq_grant_o  ( acq_grant  ),
    .acq_busy_o   ( acq_busy   ),
    .acq_full_o   ( acq_full   ),
    .start_o      ( start_o    ),
    .running_o    (            ), // Engine busy flag, no consumer at this level
    .done_pulse_o ( done_pulse ),
    .fill_ctx_o   ( fill_ctx   ),
    .run_ctx_o    ( run_ctx    ),
    .status_o     ( status_o   )
  );

  job_counters i_job_counters (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .bus_req_i    ( bus_req_i    ),
    .acq_grant_i  ( acq_grant    ),
    .done_pulse_i ( done_pulse   ),
    .offload_id_o ( offload_id   ),
    .running_id_o ( running_id   ),
    .finished_o   ( finished_cnt )
  );

  param_store #(
    .N_CONTEXT ( N_CONTEXT ),
    .N_IO_REGS ( N_IO_REGS )
  ) i_param_store (
    .clk_i      ( clk_i     ),
    .rst_ni     ( rst_ni    ),
    .clear_i    ( clear_i   ),
    .bus_req_i  ( bus_req_i ),
    .fill_ctx_i ( fill_ctx  ),
    .run_ctx_i  ( run_ctx   ),
    .rd_param_o ( rd_param  ),
    .params_o   ( params_o  )
  );

  reg_readback i_reg_readback (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .clear_i      ( clear_i      ),
    .bus_req_i    ( bus_req_i    ),
    .acq_busy_i   ( acq_busy     ),
    .acq_full_i   ( acq_full     ),
    .offload_id_i ( offload_id   ),
    .running_id_i ( running_id   ),
    .finished_i   ( finished_cnt ),
    .status_i     ( status_o     ),
    .rd_param_i   ( rd_param     ),
    .rdata_o      ( rdata_o      )
  );

endmodule

/* logic/job_counters.sv */
// Offload id, running id and finished-jobs counters
// Ids wrap at 8 bits; the finished count saturates at 2
// A FINISHED read wins over a done in the same cycle
module job_counters
  import hwpe_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  bus_req_t bus_req_i,
  input  logic     acq_grant_i,
  input  logic     done_pulse_i,
  output job_id_t  offload_id_o,
  output job_id_t  running_id_o,
  output data_t    finished_o
);

  job_id_t    offload_q;
  job_id_t    running_q;
  logic       done_q;      // Delays the running id by one cycle
  logic [1:0] fin_q;
  logic       fin_rd;

  assign fin_rd = bus_req_i.req & ~bus_req_i.wren & (bus_req_i.addr == REG_FINISHED);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      offload_q <= '0;
      running_q <= '0;
      done_q    <= 1'b0;
      fin_q     <= '0;
    end else if (clear_i) begin
      offload_q <= '0;
      running_q <= '0;
      done_q    <= 1'b0;
      fin_q     <= '0;
    end else begin
      done_q <= done_pulse_i;
      if (acq_grant_i) offload_q <= offload_q + 1'b1;
      if (done_q) running_q <= running_q + 1'b1;
      if (fin_rd) begin
        fin_q <= '0;                      // Readback already took the old value
      end else if (done_pulse_i && fin_q < 2'd2) begin
        fin_q <= fin_q + 1'b1;
      end
    end
  end

  assign offload_id_o = offload_q;
  assign running_id_o = running_q;
  assign finished_o   = data_t'(fin_q);

endmodule

/* logic/job_sched_fsm.sv */
// Context claim, trigger queue and engine start scheduler
// N_CONTEXT from 1 to 4; contexts start in trigger order
// done_i is only taken in RUN, a pulse in IDLE or START is dropped
module job_sched_fsm
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT = DEF_N_CONTEXT
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  bus_req_t bus_req_i,
  input  logic     done_i,
  output logic     acq_grant_o,
  output logic     acq_busy_o,
  output logic     acq_full_o,
  output logic     start_o,
  output logic     running_o,
  output logic     done_pulse_o,
  output ctx_id_t  fill_ctx_o,
  output ctx_id_t  run_ctx_o,
  output data_t    status_o
);

  localparam int unsigned CNT_W = $clog2(N_CONTEXT + 1);

  sched_state_e            state_q, state_d;
  logic [N_CONTEXT-1:0]    occ_q;              // Queued or running
  logic                    claim_q;            // Acquired, not yet triggered
  ctx_id_t                 fill_q;
  ctx_id_t                 run_q;
  ctx_id_t [N_CONTEXT-1:0] queue_q, queue_d;   // Trigger order, head at 0
  logic [CNT_W-1:0]        cnt_q, cnt_d;
  ctx_id_t                 free_ctx;
  logic                    acq_rd, trig_wr, all_full;
  logic                    grant, push, pop, done_ok;

  assign acq_rd   = bus_req_i.req & ~bus_req_i.wren & (bus_req_i.addr == REG_ACQUIRE);
  assign trig_wr  = bus_req_i.req & bus_req_i.wren & (bus_req_i.addr == REG_TRIGGER);
  assign all_full = &occ_q;
  assign grant    = acq_rd & ~all_full & ~claim_q;
  assign push     = trig_wr & claim_q;  // Trigger without a claim is ignored
  assign done_ok  = done_i & (state_q == SCHED_RUN);
  assign pop      = (cnt_q != '0) & ((state_q == SCHED_IDLE) | done_ok);

  // Lowest free context
  always_comb begin
    free_ctx = '0;
    for (int i = N_CONTEXT - 1; i >= 0; i--) begin
      if (!occ_q[i]) free_ctx = ctx_id_t'(i);
    end
  end

  // Queue shifts on pop, new entry goes behind the last one
  always_comb begin
    queue_d = queue_q;
    cnt_d   = cnt_q;
    if (pop) begin
      for (int i = 0; i < N_CONTEXT - 1; i++) begin
        queue_d[i] = queue_q[i+1];
      end
      cnt_d = cnt_q - CNT_W'(1);
    end
    if (push) begin
      for (int i = 0; i < N_CONTEXT; i++) begin
        if (cnt_d == CNT_W'(i)) queue_d[i] = fill_q;
      end
      cnt_d = cnt_d + CNT_W'(1);
    end
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      SCHED_IDLE:  if (pop) state_d = SCHED_START;
      SCHED_START: state_d = SCHED_RUN;
      SCHED_RUN:   if (done_ok) state_d = pop ? SCHED_START : SCHED_IDLE; // Back to back
      default:     state_d = SCHED_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= SCHED_IDLE;
      occ_q   <= '0;
      claim_q <= 1'b0;
      fill_q  <= '0;
      run_q   <= '0;
      queue_q <= '0;
      cnt_q   <= '0;
    end else if (clear_i) begin
      state_q <= SCHED_IDLE;
      occ_q   <= '0;
      claim_q <= 1'b0;
      fill_q  <= '0;
      run_q   <= '0;
      queue_q <= '0;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      queue_q <= queue_d;
      cnt_q   <= cnt_d;
      if (grant) begin
        claim_q <= 1'b1;
        fill_q  <= free_ctx;
      end else if (push) begin
        claim_q <= 1'b0;
      end
      if (pop) run_q <= queue_q[0];
      for (int i = 0; i < N_CONTEXT; i++) begin
        if (push && fill_q == ctx_id_t'(i)) occ_q[i] <= 1'b1;
        if (done_ok && run_q == ctx_id_t'(i)) occ_q[i] <= 1'b0; // Retire
      end
    end
  end

  // One byte per context, unused bytes stay 0
  always_comb begin
    status_o = '0;
    for (int i = 0; i < N_CONTEXT; i++) begin
      status_o[8*i +: 8] = {7'b0, occ_q[i]};
    end
  end

  assign acq_grant_o  = grant;
  assign acq_busy_o   = claim_q;
  assign acq_full_o   = all_full;
  assign start_o      = (state_q == SCHED_START);
  assign running_o    = (state_q != SCHED_IDLE);
  assign done_pulse_o = done_ok;
  assign fill_ctx_o   = fill_q;
  assign run_ctx_o    = run_q;

endmodule

/* logic/param_store.sv */
// Per-context parameter registers in flip-flops
// Writes and reads always address the most recently acquired context
// Unused parameter indices read back as RESP_UNMAPPED
module param_store
  import hwpe_ctrl_pkg::*;
#(
  parameter int unsigned N_CONTEXT = DEF_N_CONTEXT,
  parameter int unsigned N_IO_REGS = DEF_N_IO_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  bus_req_t              bus_req_i,
  input  ctx_id_t               fill_ctx_i,
  input  ctx_id_t               run_ctx_i,
  output data_t                 rd_param_o,
  output data_t [N_IO_REGS-1:0] params_o
);

  data_t [N_CONTEXT-1:0][N_IO_REGS-1:0] mem_q;
  data_t [N_IO_REGS-1:0]                fill_set;
  logic                                 wr;

  assign wr = bus_req_i.req & bus_req_i.wren;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_q <= '0;
    end else if (clear_i) begin
      mem_q <= '0;
    end else if (wr) begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        for (int j = 0; j < N_IO_REGS; j++) begin
          if (fill_ctx_i == ctx_id_t'(c) && bus_req_i.addr == reg_addr_t'(REG_PARAM_BASE + j))
            mem_q[c][j] <= bus_req_i.wdata;
        end
      end
    end
  end

  // Context selects for processor readback and engine
  always_comb begin
    fill_set = '0;
    params_o = '0;
    for (int c = 0; c < N_CONTEXT; c++) begin
      if (fill_ctx_i == ctx_id_t'(c)) fill_set = mem_q[c];
      if (run_ctx_i == ctx_id_t'(c)) params_o = mem_q[c];
    end
  end

  always_comb begin
    rd_param_o = RESP_UNMAPPED;
    for (int j = 0; j < N_IO_REGS; j++) begin
      if (bus_req_i.addr == reg_addr_t'(REG_PARAM_BASE + j)) rd_param_o = fill_set[j];
    end
  end

endmodule

/* logic/reg_readback.sv */
// Registered read data path
// rdata_o updates one cycle after a read strobe and holds until the next read
// Indices at and above REG_PARAM_BASE are decoded by the parameter store
module reg_readback
  import hwpe_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  input  bus_req_t bus_req_i,
  input  logic     acq_busy_i,
  input  logic     acq_full_i,
  input  job_id_t  offload_id_i,
  input  job_id_t  running_id_i,
  input  data_t    finished_i,
  input  data_t    status_i,
  input  data_t    rd_param_i,
  output data_t    rdata_o
);

  data_t rdata_q;
  data_t rdata_d;
  data_t acq_resp;
  logic  rd;

  assign rd = bus_req_i.req & ~bus_req_i.wren;

  // Full takes priority over an outstanding claim
  always_comb begin
    if (acq_full_i) acq_resp = RESP_ALL_CTX_BUSY;
    else if (acq_busy_i) acq_resp = RESP_OFFLOAD_BUSY;
    else acq_resp = data_t'(offload_id_i);  // Value before the increment
  end

  always_comb begin
    unique case (bus_req_i.addr)
      REG_ACQUIRE:    rdata_d = acq_resp;
      REG_FINISHED:   rdata_d = finished_i;
      REG_STATUS:     rdata_d = status_i;
      REG_RUNNING_ID: rdata_d = data_t'(running_id_i);
      default: begin
        if (bus_req_i.addr >= REG_PARAM_BASE) rdata_d = rd_param_i;
        else rdata_d = RESP_UNMAPPED;         // TRIGGER and indices 5 to 7
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (clear_i) begin
      rdata_q <= '0;
    end else if (rd) begin
      rdata_q <= rdata_d;
    end
  end

  assign rdata_o = rdata_q;

endmodule
